//--- hw/alu.sv
module alu
	import rv_isa_pkg::*;
(
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_t         op,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		unique case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $unsigned($signed(a) >>> shamt); // keeps the sign
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

	// branch compare reads this
	assign zero = (result == '0);

endmodule

//--- hw/cpu_control.sv
module cpu_control
	import cpu_ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	ctrl_if.control               ctrl,
	output logic                  inst_req_valid,
	input  logic                  inst_req_ready,
	input  logic                  inst_valid,
	output logic                  inst_ready,
	output logic                  mem_read,
	output logic                  mem_write,
	input  logic                  mem_req_ready,
	input  logic                  read_data_valid,
	output logic                  read_data_ready,
	output logic                  retire_valid,
	output logic [NUM_EVENTS-1:0] events
);

	state_t state;
	state_t state_next;

	logic s_if, s_iw, s_id, s_ex, s_ld, s_st, s_rdw, s_wb;

	assign s_if  = (state == S_IF);
	assign s_iw  = (state == S_IW);
	assign s_id  = (state == S_ID);
	assign s_ex  = (state == S_EX);
	assign s_ld  = (state == S_LD);
	assign s_st  = (state == S_ST);
	assign s_rdw = (state == S_RDW);
	assign s_wb  = (state == S_WB);

	always_ff @(posedge clk) begin
		if (rst)
			state <= S_INIT;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state; // hold while the partner stalls
		unique case (state)
			S_INIT: state_next = S_IF;
			S_IF:   if (inst_req_ready) state_next = S_IW;
			S_IW:   if (inst_valid) state_next = S_ID;
			S_ID:   state_next = S_EX;
			S_EX: begin
				unique case (ctrl.inst_class)
					CLS_LOAD:   state_next = S_LD;
					CLS_STORE:  state_next = S_ST;
					CLS_BRANCH: state_next = S_IF; // no write-back for branches
					default:    state_next = S_WB;
				endcase
			end
			S_LD:   if (mem_req_ready) state_next = S_RDW;
			S_ST:   if (mem_req_ready) state_next = S_IF;
			S_RDW:  if (read_data_valid) state_next = S_WB;
			S_WB:   state_next = S_IF;
			default: state_next = S_INIT;
		endcase
	end

	// handshake outputs come straight from the state
	assign inst_req_valid  = s_if;
	assign inst_ready      = s_iw;
	assign mem_read        = s_ld;
	assign mem_write       = s_st;
	assign read_data_ready = s_rdw;

	assign ctrl.inst_load    = s_iw & inst_valid;
	assign ctrl.decode_latch = s_id;
	assign ctrl.exec_latch   = s_ex;
	assign ctrl.mem_latch    = s_rdw & read_data_valid;
	assign ctrl.wb_en        = s_wb & ctrl.rd_nonzero_wen;

	// branches retire in EX, stores when the write is accepted
	assign retire_valid = s_wb
		| (s_ex & (ctrl.inst_class == CLS_BRANCH))
		| (s_st & mem_req_ready);

	always_comb begin
		events                = '0;
		events[EV_CYCLE]      = 1'b1; // counter reset covers the reset cycles
		events[EV_FETCH]      = s_if & inst_req_ready;
		events[EV_LOAD]       = s_ld & mem_req_ready;
		events[EV_STORE]      = s_st & mem_req_ready;
		events[EV_FETCH_WAIT] = s_if | s_iw;
		events[EV_LOAD_WAIT]  = s_ld | s_rdw;
		events[EV_STORE_WAIT] = s_st;
		events[EV_TAKEN]      = s_ex & ctrl.taken;
	end

endmodule

//--- hw/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// one-hot control states
	typedef enum logic [8:0] {
		S_INIT = 9'b000000001,
		S_IF   = 9'b000000010, // instruction request
		S_IW   = 9'b000000100, // waiting for instruction
		S_ID   = 9'b000001000,
		S_EX   = 9'b000010000,
		S_LD   = 9'b000100000,
		S_ST   = 9'b001000000,
		S_RDW  = 9'b010000000, // waiting for read data
		S_WB   = 9'b100000000
	} state_t;

	typedef enum logic [2:0] {
		CLS_ALU    = 3'd0,
		CLS_LOAD   = 3'd1,
		CLS_STORE  = 3'd2,
		CLS_BRANCH = 3'd3,
		CLS_JUMP   = 3'd4,
		CLS_UPPER  = 3'd5
	} inst_class_t;

	// bit positions in the event vector
	localparam int EV_CYCLE      = 0;
	localparam int EV_FETCH      = 1;
	localparam int EV_LOAD       = 2;
	localparam int EV_STORE      = 3;
	localparam int EV_FETCH_WAIT = 4;
	localparam int EV_LOAD_WAIT  = 5;
	localparam int EV_STORE_WAIT = 6;
	localparam int EV_TAKEN      = 7;
	localparam int NUM_EVENTS    = 8;

endpackage

//--- hw/cpu_datapath.sv
module cpu_datapath
	import rv_isa_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic                  clk,
	input  logic                  rst,
	ctrl_if.datapath              ctrl,
	input  logic [XLEN-1:0]       instruction,
	input  logic [XLEN-1:0]       read_data,
	output logic [XLEN-1:0]       pc,
	output logic [XLEN-1:0]       mem_address,
	output logic [XLEN-1:0]       write_data,
	output logic                  retire_wen,
	output logic [REG_ADDR_W-1:0] retire_rd,
	output logic [XLEN-1:0]       retire_data,
	output logic [XLEN-1:0]       retire_pc
);

	instr_t            ir;
	logic [XLEN-1:0]   inst_pc_q;  // pc of the instruction in flight
	logic [XLEN-1:0]   pc_plus4_q;
	logic [XLEN-1:0]   op_a_q;
	logic [XLEN-1:0]   op_b_q;
	logic [XLEN-1:0]   target_q;
	logic [XLEN-1:0]   result_q;
	logic [XLEN-1:0]   mem_q;

	inst_class_t       inst_class;
	alu_op_t           alu_op;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   rdata1, rdata2;
	logic [XLEN-1:0]   alu_b, alu_result;
	logic              alu_zero;
	logic [XLEN-1:0]   target_sum;
	logic [XLEN-1:0]   wb_data;
	logic              is_jalr, is_op;

	assign is_jalr = (ir.r.opcode == OPC_JALR);
	assign is_op   = (ir.r.opcode == OPC_OP);

	always_comb begin
		unique case (ir.r.opcode)
			OPC_LOAD:          inst_class = CLS_LOAD;
			OPC_STORE:         inst_class = CLS_STORE;
			OPC_BRANCH:        inst_class = CLS_BRANCH;
			OPC_JAL, OPC_JALR: inst_class = CLS_JUMP;
			OPC_LUI, OPC_AUIPC: inst_class = CLS_UPPER;
			default:           inst_class = CLS_ALU;
		endcase
	end

	// immediate per format
	always_comb begin
		unique case (ir.r.opcode)
			OPC_STORE:
				imm = {{20{ir.s.imm11_5[6]}}, ir.s.imm11_5, ir.s.imm4_0};
			OPC_BRANCH:
				imm = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11, ir.b.imm10_5,
					ir.b.imm4_1, 1'b0};
			OPC_LUI, OPC_AUIPC:
				imm = {ir.u.imm31_12, 12'b0};
			OPC_JAL:
				imm = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12, ir.j.imm11,
					ir.j.imm10_1, 1'b0};
			default:
				imm = {{20{ir.i.imm11_0[11]}}, ir.i.imm11_0};
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD; // address calc for loads and stores
		if (inst_class == CLS_BRANCH) begin
			if (!ir.b.funct3[2])
				alu_op = ALU_SUB;
			else if (ir.b.funct3[1])
				alu_op = ALU_SLTU;
			else
				alu_op = ALU_SLT;
		end else if (inst_class == CLS_ALU) begin
			unique case (ir.r.funct3)
				3'b000: alu_op = (is_op && ir.r.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_SLT;
				3'b011: alu_op = ALU_SLTU;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = ir.r.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	assign alu_b = (is_op || inst_class == CLS_BRANCH) ? op_b_q : imm;

	alu alu_inst (
		.a      (op_a_q),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	reg_file reg_file_inst (
		.clk    (clk),
		.wen    (ctrl.wb_en),
		.waddr  (ir.r.rd),
		.raddr1 (ir.r.rs1),
		.raddr2 (ir.r.rs2),
		.wdata  (wb_data),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// jalr is relative to rs1, everything else to the pc
	assign target_sum = (is_jalr ? rdata1 : inst_pc_q) + imm;

	assign ctrl.inst_class     = inst_class;
	assign ctrl.taken          = (inst_class == CLS_JUMP)
		| ((inst_class == CLS_BRANCH) & (ir.b.funct3[2] ^ ir.b.funct3[0] ^ alu_zero));
	assign ctrl.rd_nonzero_wen = (inst_class != CLS_BRANCH) && (inst_class != CLS_STORE)
		&& (ir.r.rd != '0);

	always_ff @(posedge clk) begin
		if (ctrl.inst_load) begin
			ir         <= instr_t'(instruction);
			inst_pc_q  <= pc;
			pc_plus4_q <= pc + XLEN'(4);
		end
		if (ctrl.decode_latch) begin
			op_a_q   <= rdata1;
			op_b_q   <= rdata2;
			target_q <= {target_sum[XLEN-1:1], target_sum[0] & ~is_jalr};
		end
		if (ctrl.exec_latch) begin
			if (inst_class == CLS_UPPER)
				result_q <= (ir.r.opcode == OPC_LUI) ? imm : target_q; // auipc = pc + imm
			else
				result_q <= alu_result;
		end
		if (ctrl.mem_latch)
			mem_q <= read_data;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (ctrl.exec_latch)
			pc <= ctrl.taken ? target_q : pc_plus4_q;
	end

	always_comb begin
		unique case (inst_class)
			CLS_JUMP: wb_data = pc_plus4_q; // link address
			CLS_LOAD: wb_data = mem_q;
			default:  wb_data = result_q;
		endcase
	end

	assign mem_address = result_q;
	assign write_data  = op_b_q;

	assign retire_wen  = ctrl.wb_en;
	assign retire_rd   = ir.r.rd;
	assign retire_data = wb_data;
	assign retire_pc   = inst_pc_q;

endmodule

//--- hw/ctrl_if.sv
interface ctrl_if
	import cpu_ctrl_pkg::*;
();

	// strobes from control
	logic        inst_load;
	logic        decode_latch;
	logic        exec_latch;
	logic        mem_latch;
	logic        wb_en;

	// status back from the datapath
	inst_class_t inst_class;
	logic        taken;
	logic        rd_nonzero_wen;

	modport control (
		output inst_load, decode_latch, exec_latch, mem_latch, wb_en,
		input  inst_class, taken, rd_nonzero_wen
	);

	modport datapath (
		input  inst_load, decode_latch, exec_latch, mem_latch, wb_en,
		output inst_class, taken, rd_nonzero_wen
	);

endinterface

//--- hw/perf_counter.sv
module perf_counter #(
	parameter int CNT_W = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             event_hit,
	output logic [CNT_W-1:0] count
);

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (event_hit)
			count <= count + CNT_W'(1); // wraps at the top
	end

endmodule

//--- hw/reg_file.sv
module reg_file
	import rv_isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  wen,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	input  logic [XLEN-1:0]       wdata,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk) begin
		if (wen)
			regs[waddr] <= wdata;
	end

	// x0 reads zero whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hw/riscv_multicycle_top.sv
module riscv_multicycle_top
	import rv_isa_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int              CNT_W    = 32,
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic                                clk,
	input  logic                                rst,
	output logic [XLEN-1:0]                     pc,
	output logic                                inst_req_valid,
	input  logic                                inst_req_ready,
	input  logic [XLEN-1:0]                     instruction,
	input  logic                                inst_valid,
	output logic                                inst_ready,
	output logic [XLEN-1:0]                     mem_address,
	output logic                                mem_write,
	output logic [XLEN-1:0]                     write_data,
	output logic                                mem_read,
	input  logic                                mem_req_ready,
	input  logic [XLEN-1:0]                     read_data,
	input  logic                                read_data_valid,
	output logic                                read_data_ready,
	output logic                                retire_valid,
	output logic                                retire_wen,
	output logic [REG_ADDR_W-1:0]               retire_rd,
	output logic [XLEN-1:0]                     retire_data,
	output logic [XLEN-1:0]                     retire_pc,
	output logic [NUM_EVENTS-1:0][CNT_W-1:0]    perf_cnt
);

	logic [NUM_EVENTS-1:0] events;

	ctrl_if ctrl_bus ();

	cpu_control cpu_control_inst (
		.clk             (clk),
		.rst             (rst),
		.ctrl            (ctrl_bus),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.retire_valid    (retire_valid),
		.events          (events)
	);

	cpu_datapath #(
		.RESET_PC (RESET_PC)
	) cpu_datapath_inst (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl_bus),
		.instruction (instruction),
		.read_data   (read_data),
		.pc          (pc),
		.mem_address (mem_address),
		.write_data  (write_data),
		.retire_wen  (retire_wen),
		.retire_rd   (retire_rd),
		.retire_data (retire_data),
		.retire_pc   (retire_pc)
	);

	// one counter per event bit
	for (genvar i = 0; i < NUM_EVENTS; i++) begin : g_perf
		perf_counter #(
			.CNT_W (CNT_W)
		) perf_counter_inst (
			.clk       (clk),
			.rst       (rst),
			.event_hit (events[i]),
			.count     (perf_cnt[i])
		);
	end

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes, bits [6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, seen through each format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the testbench, pass is decided from the log
verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f vlog.f \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "^Test completed successfully$" sim.log && exit 0 || exit 1

//--- tb/cpu_trace.txt
// @00 counts: records, program words, data pairs, store pairs; @10 program (word index)
// @30 data addr value; @38 store addr data; @40 records: pc wen rd value next_pc
@00
00000011 00000014 00000002 00000002
@10
10000093 0000A103 0040A183 00310233
4021D293 00313333 0040A423 00030463
00031463 00100393 0080046F 00200393
ABCDE4B7 00001517 00500013 041005E7
00B0A623 0021C463 00300393 00429613
@30
00000100 12345678
00000104 FFFFFFF0
@38
00000108 12345668
0000010C 00000040
@40
00000000 00000001 00000001 00000100 00000004
00000004 00000001 00000002 12345678 00000008
00000008 00000001 00000003 FFFFFFF0 0000000C
0000000C 00000001 00000004 12345668 00000010
00000010 00000001 00000005 FFFFFFFC 00000014
00000014 00000001 00000006 00000001 00000018
00000018 00000000 00000000 00000000 0000001C
0000001C 00000000 00000000 00000000 00000020
00000020 00000000 00000000 00000000 00000028
00000028 00000001 00000008 0000002C 00000030
00000030 00000001 00000009 ABCDE000 00000034
00000034 00000001 0000000A 00001034 00000038
00000038 00000000 00000000 00000000 0000003C
0000003C 00000001 0000000B 00000040 00000040
00000040 00000000 00000000 00000000 00000044
00000044 00000000 00000000 00000000 0000004C
0000004C 00000001 0000000C FFFFFFC0 00000050

//--- tb/retire_checker.sv
module retire_checker (
	input logic clk,
	input logic rst,
	input logic inst_req_valid,
	input logic inst_req_ready,
	input logic inst_valid,
	input logic inst_ready,
	input logic mem_read,
	input logic mem_write,
	input logic mem_req_ready,
	input logic read_data_valid,
	input logic read_data_ready,
	input logic retire_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// reset cycle and the INIT cycle after it
	assert property (@(posedge clk) $past(rst) |-> !(inst_req_valid | inst_ready | mem_read
		| mem_write | read_data_ready | retire_valid))
		else $error("output active during reset");

	assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ready |=> inst_req_valid)
		else $error("fetch request dropped while stalled");

	assert property (@(posedge clk) disable iff (rst)
		mem_read && !mem_req_ready |=> mem_read)
		else $error("read request dropped while stalled");

	assert property (@(posedge clk) disable iff (rst)
		mem_write && !mem_req_ready |=> mem_write)
		else $error("write request dropped while stalled");

	assert property (@(posedge clk) disable iff (rst)
		read_data_ready && !read_data_valid |=> read_data_ready)
		else $error("read_data_ready dropped while waiting");

	assert property (@(posedge clk) disable iff (rst) retire_valid |=> !retire_valid)
		else $error("retire held longer than one cycle");

endmodule

//--- tb/tb_top.sv
module tb_top
	import rv_isa_pkg::*;
	import cpu_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_REC = 40;
	localparam int PROG_BASE = 'h10;  // trace word offsets
	localparam int DATA_BASE = 'h30;
	localparam int STORE_BASE = 'h38;
	localparam int REC_BASE = 'h40;

	logic clk;
	logic rst;
	logic [XLEN-1:0] pc;
	logic inst_req_valid;
	logic inst_req_ready;
	logic [XLEN-1:0] instruction;
	logic inst_valid;
	logic inst_ready;
	logic [XLEN-1:0] mem_address;
	logic mem_write;
	logic [XLEN-1:0] write_data;
	logic mem_read;
	logic mem_req_ready;
	logic [XLEN-1:0] read_data;
	logic read_data_valid;
	logic read_data_ready;
	logic retire_valid;
	logic retire_wen;
	logic [REG_ADDR_W-1:0] retire_rd;
	logic [XLEN-1:0] retire_data;
	logic [XLEN-1:0] retire_pc;
	logic [NUM_EVENTS-1:0][31:0] perf_cnt;

	logic [31:0] trace [0:255];
	logic [31:0] pmem [0:63];
	logic [31:0] dmem [0:255];
	logic [31:0] lfsr;
	logic [31:0] exp_cnt [NUM_EVENTS];
	logic [31:0] iaddr, daddr;
	logic [31:0] next_expect, last_fetch;
	int n_rec, n_prog, n_data, n_store;
	int errors, checks, rec_idx, store_idx, low_cycles;
	int ireq_d, iresp_d, dreq_d, dresp_d;  // -1 when idle
	bit fetch_seen, counters_done;
	logic prev_ifv, prev_ifr, prev_ir, prev_iv;
	logic prev_mr, prev_mw, prev_mrdy, prev_rr, prev_rv;
	logic [31:0] prev_pc, prev_addr, prev_wdata;

	riscv_multicycle_top #(
		.CNT_W    (32),
		.RESET_PC (32'h0)
	) riscv_multicycle_top_inst (.*);

	bind cpu_control retire_checker retire_checker_inst (.*);

	always #50 clk = ~clk;

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic int draw_delay();
		int d;
		d = int'(lfsr_bit());
		d = d * 2 + int'(lfsr_bit());
		return d;
	endfunction

	// jal and jalr always redirect, even onto pc+4
	function automatic bit is_jump(input logic [31:0] word);
		return (word[6:0] == OPC_JAL) || (word[6:0] == OPC_JALR);
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
			report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic accept_store(input logic [31:0] addr, input logic [31:0] data);
		if (store_idx >= n_store) begin
			errors++;
			$display("unexpected store to %h at %0t", addr, $time);
		end else begin
			check_word("store address", addr, trace[STORE_BASE + 2 * store_idx]);
			check_word("store data", data, trace[STORE_BASE + 2 * store_idx + 1]);
		end
		dmem[addr[9:2]] = data;
		store_idx++;
	endtask

	task automatic check_retire();
		int base;
		base = REC_BASE + 5 * rec_idx;
		if (rec_idx >= n_rec) begin
			errors++;
			$display("retire beyond the end of the trace at %0t", $time);
		end else begin
			check_word("retire pc", retire_pc, trace[base]);
			check_word("retire wen", 32'(retire_wen), trace[base + 1]);
			if (trace[base + 1][0]) begin
				check_word("retire rd", 32'(retire_rd), trace[base + 2]);
				check_word("retire data", retire_data, trace[base + 3]);
			end
			next_expect = trace[base + 4];
			rec_idx++;
		end
	endtask

	// memory models, inputs change on the rising edge
	always @(posedge clk) begin
		if (rst) begin
			inst_req_ready <= 1'b0;
			inst_valid <= 1'b0;
			mem_req_ready <= 1'b0;
			read_data_valid <= 1'b0;
			ireq_d = -1;
			iresp_d = -1;
			dreq_d = -1;
			dresp_d = -1;
		end else begin
			if (inst_req_valid && inst_req_ready) begin
				inst_req_ready <= 1'b0;
				ireq_d = -1;
				iaddr = pc;
				iresp_d = draw_delay();
			end else if (inst_req_valid) begin
				if (ireq_d < 0)
					ireq_d = draw_delay();
				if (ireq_d == 0)
					inst_req_ready <= 1'b1;
				else
					ireq_d--;
			end
			if (inst_valid && inst_ready) begin
				inst_valid <= 1'b0;
			end else if (iresp_d >= 0 && !inst_valid) begin
				if (iresp_d == 0) begin
					inst_valid <= 1'b1;
					instruction <= pmem[iaddr[7:2]];
					iresp_d = -1;
				end else
					iresp_d--;
			end
			if ((mem_read || mem_write) && mem_req_ready) begin
				mem_req_ready <= 1'b0;
				dreq_d = -1;
				if (mem_write)
					accept_store(mem_address, write_data);
				else begin
					daddr = mem_address;
					dresp_d = draw_delay();
				end
			end else if (mem_read || mem_write) begin
				if (dreq_d < 0)
					dreq_d = draw_delay();
				if (dreq_d == 0)
					mem_req_ready <= 1'b1;
				else
					dreq_d--;
			end
			if (read_data_valid && read_data_ready) begin
				read_data_valid <= 1'b0;
			end else if (dresp_d >= 0 && !read_data_valid) begin
				if (dresp_d == 0) begin
					read_data_valid <= 1'b1;
					read_data <= dmem[daddr[9:2]];
					dresp_d = -1;
				end else
					dresp_d--;
			end
		end
	end

	// checks and event counts, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (!fetch_seen) begin
				low_cycles++;
				if (inst_req_valid) begin
					fetch_seen = 1'b1;
					check_word("cycles to first fetch", 32'(low_cycles), 32'd2);
				end
			end
			if (n_rec > 0 && rec_idx == n_rec && !counters_done) begin
				for (int i = 0; i < NUM_EVENTS; i++)
					check_word($sformatf("perf_cnt[%0d]", i), perf_cnt[i], exp_cnt[i]);
				counters_done = 1'b1;
			end
			if (retire_valid)
				check_retire();
			if (inst_req_valid && !prev_ifv) begin
				// instruction still holds the word served for the previous fetch
				if (pc != last_fetch + 32'd4 || is_jump(instruction))
					exp_cnt[EV_TAKEN]++;
				check_word("fetch pc", pc, next_expect);
				last_fetch = pc;
			end
			if (prev_ifv && !prev_ifr && (!inst_req_valid || pc != prev_pc))
				report_mismatch("fetch request changed while stalled");
			if (prev_ir && !prev_iv && !inst_ready)
				report_mismatch("inst_ready dropped before instruction");
			if ((prev_mr || prev_mw) && !prev_mrdy) begin
				if (mem_read != prev_mr || mem_write != prev_mw || mem_address != prev_addr
					|| (prev_mw && write_data != prev_wdata))
					report_mismatch("data request changed while stalled");
			end
			if (prev_rr && !prev_rv && !read_data_ready)
				report_mismatch("read_data_ready dropped before data");
			exp_cnt[EV_CYCLE]++;
			if (inst_req_valid && inst_req_ready)
				exp_cnt[EV_FETCH]++;
			if (mem_read && mem_req_ready)
				exp_cnt[EV_LOAD]++;
			if (mem_write && mem_req_ready)
				exp_cnt[EV_STORE]++;
			if (inst_req_valid || inst_ready)
				exp_cnt[EV_FETCH_WAIT]++;
			if (mem_read || read_data_ready)
				exp_cnt[EV_LOAD_WAIT]++;
			if (mem_write)
				exp_cnt[EV_STORE_WAIT]++;
		end
		prev_ifv = inst_req_valid;
		prev_ifr = inst_req_ready;
		prev_ir = inst_ready;
		prev_iv = inst_valid;
		prev_mr = mem_read;
		prev_mw = mem_write;
		prev_mrdy = mem_req_ready;
		prev_rr = read_data_ready;
		prev_rv = read_data_valid;
		prev_pc = pc;
		prev_addr = mem_address;
		prev_wdata = write_data;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		lfsr = 32'd91184;
		errors = 0;
		checks = 0;
		rec_idx = 0;
		store_idx = 0;
		low_cycles = 0;
		next_expect = 32'h0;
		last_fetch = 32'hfffffffc;
		for (int i = 0; i < NUM_EVENTS; i++)
			exp_cnt[i] = '0;
		$readmemh("tb/cpu_trace.txt", trace);
		n_rec = int'(trace[0]);
		n_prog = int'(trace[1]);
		n_data = int'(trace[2]);
		n_store = int'(trace[3]);
		for (int i = 0; i < 64; i++)
			pmem[i] = {i[11:0], 20'h00013}; // addi x0 filler
		for (int i = 0; i < n_prog; i++)
			pmem[i] = trace[PROG_BASE + i];
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'h5a5a0000 ^ (i * 4);
		for (int i = 0; i < n_data; i++)
			dmem[trace[DATA_BASE + 2 * i][9:2]] = trace[DATA_BASE + 2 * i + 1];
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		wait (counters_done);
		@(posedge clk);
		check_word("store count", 32'(store_idx), 32'(n_store));
		for (int i = 0; i < n_store; i++)
			check_word("final memory word", dmem[trace[STORE_BASE + 2 * i][9:2]],
				trace[STORE_BASE + 2 * i + 1]);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		#1;
		repeat (n_rec * CYCLES_PER_REC + RESET_CYCLES) @(posedge clk);
		$display("timeout after %0d of %0d retire records", rec_idx, n_rec);
		$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
hw/rv_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/ctrl_if.sv
hw/alu.sv
hw/reg_file.sv
hw/perf_counter.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/riscv_multicycle_top.sv
tb/retire_checker.sv
tb/tb_top.sv
